/* Makefile */
VERILATOR ?= verilator
TOP       ?= crc_ahb_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard verilog/*.sv) $(wildcard tb/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
verilog/crc_pkg.sv
verilog/host_interface.sv
verilog/input_buffer.sv
verilog/crc_engine.sv
verilog/crc_ahb.sv
tb/crc_ahb_checker.sv
tb/crc_ahb_tb.sv

/* tb/crc_ahb_checker.sv */
`timescale 1ns/1ps

module crc_ahb_checker
(
	input logic HCLK,
	input logic HRESETn,
	input logic HREADYOUT,
	input logic busy,
	input logic push,
	input logic pop,
	input logic empty
);

	// Slave is ready once reset has been applied
	property ready_in_reset;
		@(posedge HCLK) !HRESETn |=> HREADYOUT;
	endproperty

	// No wait state while the engine has nothing to fold
	property ready_when_idle;
		@(posedge HCLK) disable iff (!HRESETn) !busy |-> HREADYOUT;
	endproperty

	// A write strobe always leaves an entry in the buffer
	property push_lands;
		@(posedge HCLK) disable iff (!HRESETn) push |=> !empty;
	endproperty

	// An idle engine takes a new entry in the first cycle it is visible
	property pop_when_idle;
		@(posedge HCLK) disable iff (!HRESETn) (!empty && !$past(busy)) |-> pop;
	endproperty

	a_ready_in_reset:  assert property (ready_in_reset) else $error("HREADYOUT low after reset");
	a_ready_when_idle: assert property (ready_when_idle) else $error("wait state with idle engine");
	a_push_lands:      assert property (push_lands) else $error("pushed entry missing from buffer");
	a_pop_when_idle:   assert property (pop_when_idle) else $error("idle engine did not pop");

endmodule

bind crc_ahb crc_ahb_checker u_checker
(
	.HCLK      (HCLK),
	.HRESETn   (HRESETn),
	.HREADYOUT (HREADYOUT),
	.busy      (busy),
	.push      (push),
	.pop       (pop),
	.empty     (empty)
);

/* tb/crc_ahb_tb.sv */
`timescale 1ns/1ps

module crc_ahb_tb;

	import crc_pkg::*;

	// Row kinds and check kinds
	localparam logic [1:0] op_write = 2'd0;
	localparam logic [1:0] op_read  = 2'd1;
	localparam logic [1:0] chk_none  = 2'd0;
	localparam logic [1:0] chk_fixed = 2'd1;
	localparam logic [1:0] chk_model = 2'd2;

	typedef struct packed {
		logic [1:0]  op;
		logic [2:0]  addr;
		logic [1:0]  size;
		logic [31:0] data;
		logic [31:0] exp;
		logic [1:0]  chk;
	} row_t;

	logic        HCLK;
	logic        HRESETn;
	logic        HSEL;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic        HWRITE;
	logic [2:0]  HSIZE;
	logic [31:0] HWDATA;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	row_t        rows[$];
	logic        table_ready;
	logic [31:0] lfsr_q;
	int          checks;
	int          errors;

	// Reference model state right-aligned to the polynomial width
	logic [31:0] m_crc;
	logic [31:0] m_init;
	logic [31:0] m_pol;
	logic [1:0]  m_size;
	logic [1:0]  m_rev_in;
	logic        m_rev_out;

	crc_ahb #(.BUFFER_DEPTH(2)) UUT
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSEL      (HSEL),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HWRITE    (HWRITE),
		.HSIZE     (HSIZE),
		.HWDATA    (HWDATA),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	always #2 HCLK = ~HCLK;

	//////////////////////////////
	// Random data
	//////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = 32'h0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic int model_width(input logic [1:0] sz);
		case (sz)
			2'd0: return 32;
			2'd1: return 16;
			2'd2: return 8;
			default: return 7;
		endcase
	endfunction

	function automatic logic [31:0] width_mask(input int w);
		return (w == 32) ? 32'hFFFF_FFFF : ((32'h1 << w) - 32'h1);
	endfunction

	// Reverse bits in groups no wider than the written data
	function automatic logic [31:0] reverse_input(input logic [31:0] d, input int nb,
		input logic [1:0] mode);
		logic [31:0] r;
		int          g;
		r = d;
		case (mode)
			2'd0: g = 0;
			2'd1: g = 8;
			2'd2: g = (nb == 1) ? 8 : 16;
			default: g = 8 * nb;
		endcase
		if (g != 0)
			for (int s = 0; s < 8 * nb; s += g)
				for (int j = 0; j < g; j++)
					r[s + j] = d[s + g - 1 - j];
		return r;
	endfunction

	task automatic model_fold(input logic [31:0] data, input logic [1:0] size);
		logic [31:0] d;
		logic [7:0]  b;
		logic        fb;
		int          nb;
		int          w;
		nb = (size == 2'd0) ? 1 : ((size == 2'd1) ? 2 : 4);
		w  = model_width(m_size);
		d  = reverse_input(data & width_mask(8 * nb), nb, m_rev_in);
		// Most significant valid byte first with each byte MSB-first
		for (int k = nb - 1; k >= 0; k--)
		begin
			b = d[8 * k +: 8];
			for (int j = 7; j >= 0; j--)
			begin
				fb = m_crc[w - 1] ^ b[j];
				m_crc = (m_crc << 1) & width_mask(w);
				if (fb)
					m_crc = m_crc ^ (m_pol & width_mask(w));
			end
		end
	endtask

	function automatic logic [31:0] model_result();
		logic [31:0] r;
		logic [31:0] o;
		int          w;
		w = model_width(m_size);
		r = m_crc & width_mask(w);
		o = 32'h0;
		for (int i = 0; i < w; i++)
			o[i] = r[w - 1 - i];
		return m_rev_out ? o : r;
	endfunction

	task automatic model_write(input logic [2:0] addr, input logic [1:0] size,
		input logic [31:0] data);
		case (addr)
			crc_dr_addr: model_fold(data, size);
			crc_cr_addr:
			begin
				m_size    = data[4:3];
				m_rev_in  = data[6:5];
				m_rev_out = data[7];
				if (data[0])
					m_crc = m_init & width_mask(model_width(m_size));
			end
			crc_init_addr:
			begin
				m_init = data;
				m_crc  = data & width_mask(model_width(m_size));
			end
			crc_pol_addr: m_pol = data;
			default: ;
		endcase
	endtask

	//////////////////////////////
	// Table building
	//////////////////////////////

	task automatic queue_write(input logic [2:0] addr, input logic [1:0] size,
		input logic [31:0] data);
		rows.push_back('{op_write, addr, size, data, 32'h0, chk_none});
	endtask

	task automatic queue_read(input logic [2:0] addr, input logic [31:0] exp,
		input logic [1:0] chk);
		rows.push_back('{op_read, addr, 2'd2, 32'h0, exp, chk});
	endtask

	// ASCII 1 to 9 as byte writes make the usual check string
	task automatic queue_check_string();
		for (int c = 1; c <= 9; c++)
			queue_write(crc_dr_addr, 2'd0, 32'h30 + c);
	endtask

	function automatic string reg_name(input logic [2:0] addr);
		case (addr)
			crc_dr_addr:   return "DR";
			crc_idr_addr:  return "IDR";
			crc_cr_addr:   return "CR";
			crc_init_addr: return "INIT";
			crc_pol_addr:  return "POL";
			default:       return "UNMAPPED";
		endcase
	endfunction

	//////////////////////////////
	// Bus driver and check
	//////////////////////////////

	// Address phase on a falling edge and data phase until HREADYOUT is high
	task automatic bus_transfer(input logic write, input logic [2:0] addr,
		input logic [1:0] size, input logic [31:0] wdata, output logic [31:0] rdata,
		output int waits);
		waits = 0;
		@(negedge HCLK);
		HSEL   = 1'b1;
		HADDR  = {27'h0, addr, 2'b00};
		HTRANS = 2'b10;
		HWRITE = write;
		HSIZE  = {1'b0, size};
		@(negedge HCLK);
		HSEL   = 1'b0;
		HTRANS = 2'b00;
		HWDATA = wdata;
		while (!HREADYOUT)
		begin
			waits++;
			@(negedge HCLK);
		end
		rdata = HRDATA;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	// HRESP must stay OKAY for the whole run
	always @(negedge HCLK)
	begin
		if (HRESETn && HRESP)
		begin
			errors++;
			$display("HRESP went high, the slave returned an error response");
		end
	end

	//////////////////////////////
	// Watchdog
	//////////////////////////////

	initial
	begin
		wait (table_ready);
		repeat (rows.size() * 40) @(posedge HCLK);
		$display("Watchdog expired before the stimulus table finished");
		$display("Testbench failed");
		$finish;
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		logic [31:0] rdata;
		logic [31:0] exp;
		logic [31:0] cfg_word;
		row_t        r;
		int          err_before;
		int          waits;
		logic        after_data;
		HCLK        = 1'b0;
		HRESETn     = 1'b0;
		HSEL        = 1'b0;
		HADDR       = 32'h0;
		HTRANS      = 2'b00;
		HWRITE      = 1'b0;
		HSIZE       = 3'b010;
		HWDATA      = 32'h0;
		HREADY      = 1'b1;
		table_ready = 1'b0;
		lfsr_q      = 32'h32a0cfda;
		checks      = 0;
		errors      = 0;
		after_data  = 1'b0;
		m_crc       = 32'hFFFF_FFFF;
		m_init      = 32'hFFFF_FFFF;
		m_pol       = 32'h04C1_1DB7;
		m_size      = 2'd0;
		m_rev_in    = 2'd0;
		m_rev_out   = 1'b0;

		// Reset values, then register read-back
		queue_read(crc_cr_addr, 32'h0, chk_fixed);
		queue_read(crc_init_addr, 32'hFFFF_FFFF, chk_fixed);
		queue_read(crc_pol_addr, 32'h04C1_1DB7, chk_fixed);
		queue_read(crc_idr_addr, 32'h0, chk_fixed);
		queue_write(crc_idr_addr, 2'd2, 32'h0000_01A5);
		queue_read(crc_idr_addr, 32'h0000_00A5, chk_fixed);
		queue_write(crc_pol_addr, 2'd2, 32'h0000_8005);
		queue_read(crc_pol_addr, 32'h0000_8005, chk_fixed);
		queue_write(crc_init_addr, 2'd2, 32'h1234_5678);
		queue_read(crc_init_addr, 32'h1234_5678, chk_fixed);
		// Bits 2 and 0 read back as zero
		queue_write(crc_cr_addr, 2'd2, 32'h0000_001D);
		queue_read(crc_cr_addr, 32'h0000_0018, chk_fixed);
		queue_write(crc_cr_addr, 2'd2, 32'h0);
		queue_write(crc_pol_addr, 2'd2, 32'h04C1_1DB7);
		queue_write(crc_init_addr, 2'd2, 32'hFFFF_FFFF);

		// Default CRC-32 with its check value and random words
		queue_write(crc_cr_addr, 2'd2, 32'h1);
		queue_check_string();
		queue_read(crc_dr_addr, 32'h0376_E6E7, chk_fixed);
		queue_write(crc_cr_addr, 2'd2, 32'h1);
		for (int i = 0; i < 3; i++)
			queue_write(crc_dr_addr, 2'd2, rand_bits(32));
		queue_read(crc_dr_addr, 32'h0, chk_model);

		// 16-bit check value with random halfwords on top
		queue_write(crc_cr_addr, 2'd2, 32'h08);
		queue_write(crc_pol_addr, 2'd2, 32'h1021);
		queue_write(crc_init_addr, 2'd2, 32'hFFFF);
		queue_check_string();
		queue_read(crc_dr_addr, 32'h29B1, chk_fixed);
		queue_write(crc_dr_addr, 2'd1, rand_bits(16));
		queue_write(crc_dr_addr, 2'd1, rand_bits(16));
		queue_read(crc_dr_addr, 32'h0, chk_model);

		// 8-bit and 7-bit
		queue_write(crc_cr_addr, 2'd2, 32'h10);
		queue_write(crc_pol_addr, 2'd2, 32'h07);
		queue_write(crc_init_addr, 2'd2, 32'h0);
		queue_check_string();
		queue_read(crc_dr_addr, 32'hF4, chk_fixed);
		queue_write(crc_cr_addr, 2'd2, 32'h18);
		queue_write(crc_pol_addr, 2'd2, 32'h09);
		queue_write(crc_init_addr, 2'd2, 32'h0);
		queue_check_string();
		queue_read(crc_dr_addr, 32'h75, chk_fixed);
		queue_write(crc_dr_addr, 2'd0, rand_bits(8));
		queue_read(crc_dr_addr, 32'h0, chk_model);

		// Input and output reversal on CRC-32
		queue_write(crc_pol_addr, 2'd2, 32'h04C1_1DB7);
		queue_write(crc_init_addr, 2'd2, 32'hFFFF_FFFF);
		for (int m = 0; m < 4; m++)
			for (int o = 0; o < 2; o++)
			begin
				cfg_word = (32'(o) << 7) | (32'(m) << 5);
				queue_write(crc_cr_addr, 2'd2, cfg_word);
				queue_write(crc_cr_addr, 2'd2, cfg_word | 32'h1);
				queue_write(crc_dr_addr, 2'd2, rand_bits(32));
				queue_write(crc_dr_addr, 2'd1, rand_bits(16));
				queue_write(crc_dr_addr, 2'd0, rand_bits(8));
				queue_read(crc_dr_addr, 32'h0, chk_model);
			end

		// More words than the buffer holds with a read straight after
		queue_write(crc_cr_addr, 2'd2, 32'h0);
		queue_write(crc_cr_addr, 2'd2, 32'h1);
		for (int i = 0; i < 6; i++)
			queue_write(crc_dr_addr, 2'd2, rand_bits(32));
		queue_read(crc_dr_addr, 32'h0, chk_model);
		table_ready = 1'b1;

		repeat (5) @(posedge HCLK);
		@(negedge HCLK);
		HRESETn = 1'b1;

		for (int i = 0; i < rows.size(); i++)
		begin
			r = rows[i];
			bus_transfer(r.op == op_write, r.addr, r.size, r.data, rdata, waits);
			if (r.op == op_write)
				model_write(r.addr, r.size, r.data);
			else if (r.chk != chk_none)
			begin
				exp = (r.chk == chk_model) ? model_result() : r.exp;
				err_before = errors;
				check_value(reg_name(r.addr), rdata, exp);
				// Bytes still folding, so the result read has to stall
				if (after_data)
					check_value("HREADYOUT wait", (waits > 0) ? 32'h1 : 32'h0, 32'h1);
				$display("Row %0d read %s: %s", i, reg_name(r.addr),
					(errors == err_before) ? "ok" : "error");
			end
			after_data = (r.op == op_write) && (r.addr == crc_dr_addr);
		end

		$display("Rows: %0d, checks: %0d, errors: %0d", rows.size(), checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* verilog/crc_ahb.sv */
`timescale 1ns/1ps

module crc_ahb
#(
	parameter int BUFFER_DEPTH = 2
)
(
	input  logic        HCLK,
	input  logic        HRESETn,
	// AHB-Lite slave port
	input  logic        HSEL,
	input  logic [31:0] HADDR,
	input  logic [1:0]  HTRANS,
	input  logic        HWRITE,
	input  logic [2:0]  HSIZE,
	input  logic [31:0] HWDATA,
	input  logic        HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);

	import crc_pkg::*;

	// Front end to buffer
	logic        push;
	buf_entry_t  push_entry;
	logic        full;
	// Buffer to engine
	buf_entry_t  pop_entry;
	logic        empty;
	logic        pop;
	// Front end and engine
	reg_wr_t     reg_wr;
	crc_cfg_t    cfg;
	logic        busy;
	logic [31:0] crc_out;
	logic [31:0] init_out;
	logic [31:0] pol_out;
	logic [7:0]  idr_out;

	//////////////////////////////
	// Bus front end
	//////////////////////////////

	host_interface u_host_interface
	(
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.HSEL       (HSEL),
		.HADDR      (HADDR),
		.HTRANS     (HTRANS),
		.HWRITE     (HWRITE),
		.HSIZE      (HSIZE),
		.HWDATA     (HWDATA),
		.HREADY     (HREADY),
		.HRDATA     (HRDATA),
		.HREADYOUT  (HREADYOUT),
		.HRESP      (HRESP),
		.full       (full),
		.push       (push),
		.push_entry (push_entry),
		.busy       (busy),
		.crc_out    (crc_out),
		.init_out   (init_out),
		.pol_out    (pol_out),
		.idr_out    (idr_out),
		.reg_wr     (reg_wr),
		.cfg        (cfg)
	);

	//////////////////////////////
	// Data FIFO
	//////////////////////////////

	input_buffer
	#(
		.BUFFER_DEPTH (BUFFER_DEPTH)
	)
	u_input_buffer
	(
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.push       (push),
		.push_entry (push_entry),
		.pop        (pop),
		.pop_entry  (pop_entry),
		.full       (full),
		.empty      (empty)
	);

	//////////////////////////////
	// CRC datapath
	//////////////////////////////

	crc_engine u_crc_engine
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.reg_wr    (reg_wr),
		.cfg       (cfg),
		.pop_entry (pop_entry),
		.empty     (empty),
		.pop       (pop),
		.busy      (busy),
		.crc_out   (crc_out),
		.init_out  (init_out),
		.pol_out   (pol_out),
		.idr_out   (idr_out)
	);

endmodule

/* verilog/crc_engine.sv */
`timescale 1ns/1ps

module crc_engine
(
	input  logic                HCLK,
	input  logic                HRESETn,
	// From the bus front end
	input  crc_pkg::reg_wr_t    reg_wr,
	input  crc_pkg::crc_cfg_t   cfg,
	// Input buffer
	input  crc_pkg::buf_entry_t pop_entry,
	input  logic                empty,
	output logic                pop,
	// Status and read values
	output logic                busy,
	output logic [31:0]         crc_out,
	output logic [31:0]         init_out,
	output logic [31:0]         pol_out,
	output logic [7:0]          idr_out
);

	import crc_pkg::*;

	logic [31:0] init_q;
	logic [31:0] pol_q;
	logic [7:0]  idr_q;
	// CRC state, left-aligned to bit 31
	logic [31:0] crc_q;
	// Pending bytes, next one in [31:24]
	logic [31:0] shift_q;
	logic [2:0]  bytes_left;

	logic [4:0]  align_sh;
	logic [31:0] top_mask;
	logic [31:0] poly_aligned;
	logic [31:0] init_aligned;
	logic [31:0] state_masked;
	logic [31:0] rev_data;
	logic [31:0] load_data;
	logic [2:0]  load_bytes;
	logic [31:0] crc_next;
	logic        fold;
	logic        load_state;

	// Bit reversal inside groups of grp bits
	function automatic logic [31:0] rev_group(input logic [31:0] d, input int grp);
		logic [31:0] r;
		for (int i = 0; i < 32; i++)
			r[i] = d[(i / grp) * grp + grp - 1 - (i % grp)];
		return r;
	endfunction

	// One byte MSB-first through the LFSR
	function automatic logic [31:0] fold_byte(input logic [31:0] state, input logic [7:0] b,
		input logic [31:0] poly, input logic [31:0] mask);
		logic [31:0] c;
		logic        fb;
		c = state;
		for (int i = 7; i >= 0; i--)
		begin
			fb = c[31] ^ b[i];
			c  = c << 1;
			if (fb)
				c = c ^ poly;
		end
		return c & mask;
	endfunction

	//////////////////////////////
	// Polynomial width
	//////////////////////////////

	always_comb
	begin
		case (cfg.poly_size)
			poly_32: align_sh = 5'd0;
			poly_16: align_sh = 5'd16;
			poly_8:  align_sh = 5'd24;
			default: align_sh = 5'd25;
		endcase
	end

	assign top_mask     = 32'hFFFF_FFFF << align_sh;
	assign poly_aligned = pol_q << align_sh;
	// A fresh INIT write loads its own value
	assign init_aligned = (reg_wr.init_en ? reg_wr.wdata : init_q) << align_sh;
	assign state_masked = crc_q & top_mask;

	//////////////////////////////
	// Input reversal and alignment
	//////////////////////////////

	// Reversal never reaches past the written width
	always_comb
	begin
		case (cfg.rev_in)
			rev_none: rev_data = pop_entry.data;
			rev_byte: rev_data = rev_group(pop_entry.data, 8);
			rev_half:
				if (pop_entry.size == hsize_byte)
					rev_data = rev_group(pop_entry.data, 8);
				else
					rev_data = rev_group(pop_entry.data, 16);
			default:
				case (pop_entry.size)
					hsize_byte: rev_data = rev_group(pop_entry.data, 8);
					hsize_half: rev_data = rev_group(pop_entry.data, 16);
					default:    rev_data = rev_group(pop_entry.data, 32);
				endcase
		endcase
	end

	// Most significant valid byte goes first
	always_comb
	begin
		case (pop_entry.size)
			hsize_byte:
			begin
				load_data  = {rev_data[7:0], 24'h0};
				load_bytes = 3'd1;
			end
			hsize_half:
			begin
				load_data  = {rev_data[15:0], 16'h0};
				load_bytes = 3'd2;
			end
			default:
			begin
				load_data  = rev_data;
				load_bytes = 3'd4;
			end
		endcase
	end

	//////////////////////////////
	// Folding
	//////////////////////////////

	assign fold       = (bytes_left != 3'd0);
	assign load_state = reg_wr.reset_chain || reg_wr.init_en;
	assign crc_next   = fold_byte(crc_q, shift_q[31:24], poly_aligned, top_mask);
	// Take the next entry while the last byte of this one folds
	assign pop        = !empty && (bytes_left <= 3'd1);
	assign busy       = fold || !empty;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_q     <= crc_init_reset;
			pol_q      <= crc_pol_reset;
			idr_q      <= 8'h00;
			crc_q      <= crc_init_reset;
			bytes_left <= 3'd0;
		end
		else
		begin
			if (reg_wr.init_en)
				init_q <= reg_wr.wdata;
			if (reg_wr.pol_en)
				pol_q <= reg_wr.wdata;
			if (reg_wr.idr_en)
				idr_q <= reg_wr.wdata[7:0];
			// Reload wins over a fold in the same cycle
			if (load_state)
				crc_q <= init_aligned;
			else if (fold)
				crc_q <= crc_next;
			if (pop)
				bytes_left <= load_bytes;
			else if (fold)
				bytes_left <= bytes_left - 3'd1;
		end
	end

	// Shift register holds payload only
	always_ff @(posedge HCLK)
	begin
		if (pop)
			shift_q <= load_data;
		else if (fold)
			shift_q <= shift_q << 8;
	end

	//////////////////////////////
	// Outputs
	//////////////////////////////

	// Full reversal of the aligned state lands right-aligned
	assign crc_out  = cfg.rev_out ? rev_group(state_masked, 32) : (state_masked >> align_sh);
	assign init_out = init_q;
	assign pol_out  = pol_q;
	assign idr_out  = idr_q;

endmodule

/* verilog/crc_pkg.sv */
package crc_pkg;

	//////////////////////////////
	// Register map
	//////////////////////////////

	// Word offsets taken from HADDR[4:2]
	localparam logic [2:0] crc_dr_addr   = 3'd0;
	localparam logic [2:0] crc_idr_addr  = 3'd1;
	localparam logic [2:0] crc_cr_addr   = 3'd2;
	localparam logic [2:0] crc_init_addr = 3'd4;
	localparam logic [2:0] crc_pol_addr  = 3'd5;

	// Reset values
	localparam logic [31:0] crc_init_reset = 32'hFFFF_FFFF;
	localparam logic [31:0] crc_pol_reset  = 32'h04C1_1DB7;
	localparam logic [4:0]  crc_cr_reset   = 5'h00;

	//////////////////////////////
	// AHB encodings
	//////////////////////////////

	typedef enum logic [1:0] {
		htrans_idle   = 2'b00,
		htrans_busy   = 2'b01,
		htrans_nonseq = 2'b10,
		htrans_seq    = 2'b11
	} htrans_t;

	// Low two bits of HSIZE only
	typedef enum logic [1:0] {
		hsize_byte = 2'b00,
		hsize_half = 2'b01,
		hsize_word = 2'b10
	} hsize_t;

	//////////////////////////////
	// CRC configuration
	//////////////////////////////

	typedef enum logic [1:0] {
		poly_32 = 2'b00,
		poly_16 = 2'b01,
		poly_8  = 2'b10,
		poly_7  = 2'b11
	} poly_size_t;

	typedef enum logic [1:0] {
		rev_none = 2'b00,
		rev_byte = 2'b01,
		rev_half = 2'b10,
		rev_word = 2'b11
	} rev_in_t;

	// Same bit order as CR[7:3]
	typedef struct packed {
		logic       rev_out;
		rev_in_t    rev_in;
		poly_size_t poly_size;
	} crc_cfg_t;

	// One buffered data write
	typedef struct packed {
		logic [31:0] data;
		hsize_t      size;
	} buf_entry_t;

	// Register writes towards the engine
	typedef struct packed {
		logic [31:0] wdata;
		logic        init_en;
		logic        pol_en;
		logic        idr_en;
		logic        reset_chain;
	} reg_wr_t;

endpackage

/* verilog/host_interface.sv */
`timescale 1ns/1ps

module host_interface
(
	input  logic                HCLK,
	input  logic                HRESETn,
	// AHB-Lite slave side
	input  logic                HSEL,
	input  logic [31:0]         HADDR,
	input  logic [1:0]          HTRANS,
	input  logic                HWRITE,
	input  logic [2:0]          HSIZE,
	input  logic [31:0]         HWDATA,
	input  logic                HREADY,
	output logic [31:0]         HRDATA,
	output logic                HREADYOUT,
	output logic                HRESP,
	// Input buffer
	input  logic                full,
	output logic                push,
	output crc_pkg::buf_entry_t push_entry,
	// CRC engine
	input  logic                busy,
	input  logic [31:0]         crc_out,
	input  logic [31:0]         init_out,
	input  logic [31:0]         pol_out,
	input  logic [7:0]          idr_out,
	output crc_pkg::reg_wr_t    reg_wr,
	output crc_pkg::crc_cfg_t   cfg
);

	import crc_pkg::*;

	// Address phase copies
	logic [2:0]  haddr_q;
	hsize_t      hsize_q;
	htrans_t     htrans_q;
	logic        hwrite_q;
	logic        hsel_q;

	// Control register
	crc_cfg_t    cfg_q;

	logic        sample_bus;
	logic        write_en;
	logic        read_en;
	logic        dr_wr;
	logic        dr_rd;
	logic        idr_wr;
	logic        cr_wr;
	logic        init_wr;
	logic        pol_wr;
	logic        read_wait;
	logic        reset_pending;
	logic [31:0] dr_wdata;

	//////////////////////////////
	// Address phase
	//////////////////////////////

	// Only sampled when the bus moves on
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hsel_q   <= 1'b0;
			htrans_q <= htrans_idle;
		end
		else if (sample_bus)
		begin
			hsel_q   <= HSEL;
			htrans_q <= htrans_t'(HTRANS);
		end
	end

	// Qualified by hsel_q, so no reset needed here
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_q  <= HADDR[4:2];
			hsize_q  <= hsize_t'(HSIZE[1:0]);
			hwrite_q <= HWRITE;
		end
	end

	//////////////////////////////
	// Decode
	//////////////////////////////

	// Idle, busy and seq transfers do nothing
	assign write_en = hsel_q && (htrans_q == htrans_nonseq) && hwrite_q;
	assign read_en  = hsel_q && (htrans_q == htrans_nonseq) && !hwrite_q;

	assign dr_wr   = write_en && (haddr_q == crc_dr_addr);
	assign dr_rd   = read_en  && (haddr_q == crc_dr_addr);
	assign idr_wr  = write_en && (haddr_q == crc_idr_addr);
	assign cr_wr   = write_en && (haddr_q == crc_cr_addr);
	assign init_wr = write_en && (haddr_q == crc_init_addr);
	assign pol_wr  = write_en && (haddr_q == crc_pol_addr);

	// The engine reports only busy, the bus side decides what to stall
	assign read_wait     = busy;
	assign reset_pending = busy;

	//////////////////////////////
	// Handshake
	//////////////////////////////

	// Stall on full buffer, result not ready, or INIT reload mid-calculation
	assign HREADYOUT = !((dr_wr   && full)      ||
	                     (dr_rd   && read_wait) ||
	                     (init_wr && reset_pending));

	// Always OKAY
	assign HRESP = 1'b0;

	//////////////////////////////
	// Data register writes
	//////////////////////////////

	// Sub-word data sits in the low lanes
	always_comb
	begin
		case (hsize_q)
			hsize_byte: dr_wdata = {24'h0, HWDATA[7:0]};
			hsize_half: dr_wdata = {16'h0, HWDATA[15:0]};
			default:    dr_wdata = HWDATA;
		endcase
	end

	// Push happens in the last data phase cycle
	assign push            = dr_wr && !full;
	assign push_entry.data = dr_wdata;
	assign push_entry.size = hsize_q;

	//////////////////////////////
	// Register writes
	//////////////////////////////

	assign reg_wr.wdata       = HWDATA;
	// INIT takes effect only once the stall is over
	assign reg_wr.init_en     = init_wr && !reset_pending;
	assign reg_wr.pol_en      = pol_wr;
	assign reg_wr.idr_en      = idr_wr;
	// Self-clearing, CR bit 0 is never stored
	assign reg_wr.reset_chain = cr_wr && HWDATA[0];

	// CR bits 7:3 map straight onto the config struct
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cfg_q <= crc_cfg_t'(crc_cr_reset);
		else if (cr_wr)
			cfg_q <= crc_cfg_t'(HWDATA[7:3]);
	end

	assign cfg = cfg_q;

	//////////////////////////////
	// Read mux
	//////////////////////////////

	always_comb
	begin
		case (haddr_q)
			crc_dr_addr:   HRDATA = crc_out;
			crc_idr_addr:  HRDATA = {24'h0, idr_out};
			crc_cr_addr:   HRDATA = {24'h0, cfg_q, 3'h0};
			crc_init_addr: HRDATA = init_out;
			crc_pol_addr:  HRDATA = pol_out;
			// Unmapped offsets read as zero
			default:       HRDATA = 32'h0;
		endcase
	end

endmodule

/* verilog/input_buffer.sv */
`timescale 1ns/1ps

module input_buffer
#(
	parameter int BUFFER_DEPTH = 2
)
(
	input  logic                HCLK,
	input  logic                HRESETn,
	// Write side from the bus front end
	input  logic                push,
	input  crc_pkg::buf_entry_t push_entry,
	// Read side towards the engine
	input  logic                pop,
	output crc_pkg::buf_entry_t pop_entry,
	output logic                full,
	output logic                empty
);

	import crc_pkg::*;

	// Depth is a power of two, pointers wrap on their own
	localparam int PTR_W = $clog2(BUFFER_DEPTH);

	buf_entry_t       mem [BUFFER_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	// Ignore requests that would overflow or underflow
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	//////////////////////////////
	// Storage
	//////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (do_push)
			mem[wr_ptr] <= push_entry;
	end

	// Head entry visible the cycle after its push
	assign pop_entry = mem[rd_ptr];

	//////////////////////////////
	// Pointers and fill level
	//////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leaves the count alone
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	assign full  = (count == (PTR_W+1)'(BUFFER_DEPTH));
	assign empty = (count == '0);

endmodule
